//--- Makefile
VERILATOR ?= verilator
TOP       ?= heapMemoryTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/arraySizeTable.sv
/*
  Array size table
  Current size of every array, updated by Write, Push, Pop and Alloc
*/
`timescale 1ns/10ps

module arraySizeTable import heapPkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        sizeWriteEn,
  input  logic        sizeIncEn,
  input  logic        sizeDecEn,
  input  logic        sizeResetEn,
  input  arrayNum     array,
  input  elementIndex index,
  output arraySize    currentSize
);

  arraySize sizes [numArrays];
  arraySize writeSize;                           // Size implied by a write at index
  logic     beyondEnd;

  assign currentSize = sizes[array];
  assign writeSize   = {1'b0, index} + 1'b1;
  assign beyondEnd   = {1'b0, index} >= sizes[array];

  // --------------------------------------------------
  // Size updates
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < numArrays; i++) begin
        sizes[i] <= '0;
      end
    end else if (sizeResetEn) begin              // Alloc starts empty
      sizes[array] <= '0;
    end else if (sizeWriteEn) begin
      if (beyondEnd) begin
        sizes[array] <= writeSize;               // Extend up to the written slot
      end
    end else if (sizeIncEn) begin                // Push
      sizes[array] <= sizes[array] + 1'b1;
    end else if (sizeDecEn) begin                // Pop
      sizes[array] <= sizes[array] - 1'b1;
    end
  end

endmodule

//--- logic/elementStore.sv
/*
  Element store
  Two-dimensional element memory, one write port and a combinational read port
*/
`timescale 1ns/10ps

module elementStore import heapPkg::*; (
  input  logic        clock,
  input  logic        storeEn,
  input  arrayNum     array,
  input  elementIndex readIndex,
  input  elementIndex storeIndex,
  input  elementData  storeData,
  output elementData  readData
);

  elementData memory [numArrays][arrayLength];   // Fixed block per array

  // --------------------------------------------------
  // Read side
  // Pop addresses one below the size, others the command index
  assign readData = memory[array][readIndex];

  // --------------------------------------------------
  // Write side
  always_ff @(posedge clock) begin
    if (storeEn) begin
      memory[array][storeIndex] <= storeData;    // Write, Push or Add result
    end
  end

endmodule

//--- logic/heapAllocator.sv
/*
  Heap allocator
  Hands out array numbers, reusing freed arrays last-in first-out
*/
`timescale 1ns/10ps

module heapAllocator import heapPkg::*; (
  input  logic    clock,
  input  logic    resetN,
  input  logic    allocEn,
  input  logic    freeEn,
  input  logic    clearEn,
  input  arrayNum array,
  output logic    allocated,
  output logic    freed,
  output logic    full,
  output arrayNum nextArray
);

  logic [arrayBits:0]   handedCount;             // Arrays handed out since reset
  logic [arrayBits:0]   stackTop;                // Entries on the freed stack
  logic [numArrays-1:0] freedFlags;              // One per array
  arrayNum              freeStack [numArrays];
  arrayNum              topIndex;

  // --------------------------------------------------
  // Status towards the controller
  assign topIndex  = stackTop[arrayBits-1:0] - 1'b1;
  assign allocated = {1'b0, array} < handedCount;
  assign freed     = freedFlags[array];
  // Top bit of the count means every number is used
  assign full      = (stackTop == '0) && handedCount[arrayBits];
  assign nextArray = (stackTop != '0) ? freeStack[topIndex] : handedCount[arrayBits-1:0];

  // --------------------------------------------------
  // Counters and flags
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      handedCount <= '0;
      stackTop    <= '0;
      freedFlags  <= '0;
    end else if (clearEn) begin                  // opReset
      handedCount <= '0;
      stackTop    <= '0;
      freedFlags  <= '0;
    end else if (allocEn) begin
      if (stackTop != '0) begin                  // Reuse the latest freed array
        stackTop              <= stackTop - 1'b1;
        freedFlags[nextArray] <= 1'b0;
      end else begin
        handedCount <= handedCount + 1'b1;       // Fresh number
      end
    end else if (freeEn) begin
      stackTop          <= stackTop + 1'b1;
      freedFlags[array] <= 1'b1;
    end
  end

  // Freed numbers, valid below stackTop
  always_ff @(posedge clock) begin
    if (freeEn) begin
      freeStack[stackTop[arrayBits-1:0]] <= array;
    end
  end

endmodule

//--- logic/heapController.sv
/*
  Heap controller
  Checks each command, raises the storage enables for commands that pass
  and registers the one-cycle response
*/
`timescale 1ns/10ps

module heapController import heapPkg::*, heapOpsPkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        start,
  input  heapAction   action,
  input  arrayNum     array,
  input  elementIndex index,
  input  elementData  dataIn,
  input  logic        allocated,
  input  logic        freed,
  input  logic        full,
  input  arrayNum     nextArray,
  input  arraySize    currentSize,
  input  elementData  readData,
  output logic        allocEn,
  output logic        freeEn,
  output logic        clearEn,
  output logic        sizeWriteEn,
  output logic        sizeIncEn,
  output logic        sizeDecEn,
  output logic        sizeResetEn,
  output logic        storeEn,
  output arrayNum     sizeArray,
  output elementIndex readIndex,
  output elementIndex storeIndex,
  output elementData  storeData,
  output logic        done,
  output elementData  dataOut,
  output heapError    error
);

  ctrlState   state;
  heapError   errorNext;
  elementData resultNext;
  elementData sum;
  logic       pass;
  logic       inBounds;
  logic       checkArray;                        // Command names an existing array

  assign checkArray = (action != opAlloc) && (action != opReset);
  assign inBounds   = {1'b0, index} < currentSize;
  assign sum        = readData + dataIn;         // Wraps to dataBits

  // --------------------------------------------------
  // Error rules, highest priority first
  always_comb begin
    errorNext = errNone;
    if (checkArray && !allocated) begin
      errorNext = errNotAllocated;
    end else if (checkArray && freed) begin
      errorNext = errFreed;
    end else begin
      case (action)
        opRead, opAdd: if (!inBounds) errorNext = errOutOfBounds;
        opPush:  if (currentSize == arraySize'(arrayLength)) errorNext = errFull;
        opPop:   if (currentSize == '0) errorNext = errEmpty;
        opAlloc: if (full) errorNext = errNoMemory;
        opWrite, opSize, opFree, opReset: errorNext = errNone;
        default: errorNext = errBadAction;
      endcase
    end
  end

  assign pass = (errorNext == errNone);

  // --------------------------------------------------
  // Enables, only for commands that pass
  assign allocEn     = start && pass && (action == opAlloc);
  assign freeEn      = start && pass && (action == opFree);
  assign clearEn     = start && (action == opReset);
  assign sizeWriteEn = start && pass && (action == opWrite);
  assign sizeIncEn   = start && pass && (action == opPush);
  assign sizeDecEn   = start && pass && (action == opPop);
  assign sizeResetEn = allocEn;                  // New array starts empty
  assign storeEn     = start && pass &&
                       (action == opWrite || action == opPush || action == opAdd);

  // Addressing for the size table and the store
  assign sizeArray  = (action == opAlloc) ? nextArray : array;
  assign storeIndex = (action == opPush) ? currentSize[indexBits-1:0] : index;
  assign readIndex  = (action == opPop) ? currentSize[indexBits-1:0] - 1'b1 : index;
  assign storeData  = (action == opAdd) ? sum : dataIn;

  // --------------------------------------------------
  // Response data
  always_comb begin
    resultNext = '0;
    if (pass) begin
      case (action)
        opAlloc: resultNext = elementData'(nextArray);
        opWrite: resultNext = dataIn;            // Echo
        opRead:  resultNext = readData;
        opSize:  resultNext = elementData'(currentSize);
        opPop:   resultNext = readData;          // Element at the new size
        opAdd:   resultNext = sum;
        default: resultNext = '0;                // Free and Reset
      endcase
    end
  end

  // --------------------------------------------------
  // Response registers
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state   <= idle;
      dataOut <= '0;
      error   <= errNone;
    end else begin
      state <= start ? respond : idle;           // One cycle per command
      if (start) begin
        dataOut <= resultNext;
        error   <= errorNext;
      end
    end
  end

  assign done = (state == respond);

endmodule

//--- logic/heapMemory.sv
/*
  Heap memory
  Fixed set of arrays with allocation, element access, push, pop and add
*/
`timescale 1ns/10ps

module heapMemory import heapPkg::*, heapOpsPkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        start,
  input  heapAction   action,
  input  arrayNum     array,
  input  elementIndex index,
  input  elementData  dataIn,
  output logic        done,
  output elementData  dataOut,
  output heapError    error
);

  // --------------------------------------------------
  // Allocator wires
  logic        allocEn;
  logic        freeEn;
  logic        clearEn;
  logic        allocated;
  logic        freed;
  logic        full;
  arrayNum     nextArray;

  // Size table wires
  logic        sizeWriteEn;
  logic        sizeIncEn;
  logic        sizeDecEn;
  logic        sizeResetEn;
  arrayNum     sizeArray;
  arraySize    currentSize;

  // Store wires
  logic        storeEn;
  elementIndex readIndex;
  elementIndex storeIndex;
  elementData  storeData;
  elementData  readData;

  heapController controller (
    .clock, .resetN, .start, .action, .array, .index, .dataIn,
    .allocated, .freed, .full, .nextArray, .currentSize, .readData,
    .allocEn, .freeEn, .clearEn,
    .sizeWriteEn, .sizeIncEn, .sizeDecEn, .sizeResetEn,
    .storeEn, .sizeArray, .readIndex, .storeIndex, .storeData,
    .done, .dataOut, .error
  );

  heapAllocator allocator (
    .clock, .resetN, .allocEn, .freeEn, .clearEn, .array,
    .allocated, .freed, .full, .nextArray
  );

  arraySizeTable sizeTable (
    .clock, .resetN, .sizeWriteEn, .sizeIncEn, .sizeDecEn, .sizeResetEn,
    .array (sizeArray),                          // nextArray during Alloc
    .index,
    .currentSize
  );

  elementStore store (
    .clock, .storeEn, .array, .readIndex, .storeIndex, .storeData, .readData
  );

endmodule

//--- logic/heapOpsPkg.sv
/*
  Heap operations
  Command codes, error codes and the controller phases
*/
package heapOpsPkg;

  // --------------------------------------------------
  // Commands, numbered as in the original heap
  typedef enum logic [7:0] {
    opReset = 8'd1,    // Clear the allocator
    opWrite = 8'd2,    // Write an element
    opRead  = 8'd3,    // Read an element
    opSize  = 8'd4,    // Size of an array
    opPush  = 8'd14,   // Append to an array
    opPop   = 8'd15,   // Remove the last element
    opAlloc = 8'd18,   // Hand out an array
    opFree  = 8'd19,   // Return an array
    opAdd   = 8'd20    // Add, returning the new value
  } heapAction;

  // --------------------------------------------------
  // Error codes
  typedef enum logic [3:0] {
    errNone         = 4'd0,
    errNotAllocated = 4'd1,   // Never handed out
    errFreed        = 4'd2,   // Currently freed
    errOutOfBounds  = 4'd3,   // Index not below size
    errFull         = 4'd4,   // Push to a full array
    errEmpty        = 4'd5,   // Pop from an empty array
    errNoMemory     = 4'd6,   // No array left
    errBadAction    = 4'd7    // Unknown command
  } heapError;

  typedef enum logic {
    idle,
    respond
  } ctrlState;

endpackage

//--- logic/heapPkg.sv
/*
  Heap geometry
  Array count, array length, element width and the vector types built on them
*/
package heapPkg;

  // --------------------------------------------------
  // Geometry
  localparam int arrayBits   = 2;                // Bits in an array number
  localparam int indexBits   = 3;                // Bits in an element index
  localparam int dataBits    = 12;               // Element width
  localparam int numArrays   = 1 << arrayBits;   // Arrays in the heap
  localparam int arrayLength = 1 << indexBits;   // Elements per array

  // --------------------------------------------------
  // Vector types
  typedef logic [arrayBits-1:0] arrayNum;        // Array number
  typedef logic [indexBits-1:0] elementIndex;    // Index within an array
  typedef logic [indexBits:0]   arraySize;       // Extra bit so a full array fits
  typedef logic [dataBits-1:0]  elementData;     // One element

endpackage

//--- tb.f
logic/heapPkg.sv
logic/heapOpsPkg.sv
logic/heapAllocator.sv
logic/arraySizeTable.sv
logic/elementStore.sv
logic/heapController.sv
logic/heapMemory.sv
tb/heapMemory_asserts.sv
tb/tbClock.sv
tb/heapChecker.sv
tb/heapMemoryTb.sv

//--- tb/heapChecker.sv
/*
  Response checker
  Holds the expectation of each command and compares it with the done response
*/
`timescale 1ns/10ps

module heapChecker import heapPkg::*, heapOpsPkg::*; (
  input  logic         clock,
  input  logic         resetN,
  input  logic         expValid,
  input  logic [191:0] expName,
  input  elementData   expData,
  input  heapError     expError,
  input  logic         done,
  input  elementData   dataOut,
  input  heapError     error,
  output int           mismatchCount,
  output int           handshakeCount,
  output int           checkedCount
);

  logic         pendValid;                       // Command sampled at the last edge
  logic [191:0] pendName;
  elementData   pendData;
  heapError     pendError;

  initial begin
    mismatchCount  = 0;
    handshakeCount = 0;
    checkedCount   = 0;
  end

  // --------------------------------------------------
  // Expectation follows the command into the DUT
  always @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      pendValid <= 1'b0;
    end else begin
      pendValid <= expValid;
      pendName  <= expName;
      pendData  <= expData;
      pendError <= expError;
    end
  end

  // --------------------------------------------------
  // Compare mid-cycle while the response is stable
  always @(negedge clock) begin
    if (resetN === 1'b1) begin
      if (pendValid && done !== 1'b1) begin
        $display("no done response for command %0s", string'(pendName));
        handshakeCount++;
        checkedCount++;
      end else if (!pendValid && done !== 1'b0) begin
        $display("done was raised without a command");
        handshakeCount++;
      end else if (pendValid) begin
        checkedCount++;
        if (dataOut !== pendData) begin
          $display("mismatch %0s dataOut expected %h actual %h",
                   string'(pendName), pendData, dataOut);
          mismatchCount++;
        end
        if (error !== pendError) begin
          $display("mismatch %0s error expected %0s actual %0s (%0d)",
                   string'(pendName), pendError.name(), error.name(), error);
          mismatchCount++;
        end
      end
    end
  end

endmodule

//--- tb/heapMemoryTb.sv
/*
  Heap memory testbench
  Applies a command table back to back and checks every response
*/
`timescale 1ns/10ps

module heapMemoryTb import heapPkg::*, heapOpsPkg::*;;

  logic         clock;
  logic         resetN;
  logic         start;
  heapAction    action;
  arrayNum      array;
  elementIndex  index;
  elementData   dataIn;
  logic         done;
  elementData   dataOut;
  heapError     error;
  logic [191:0] expName;                         // ASCII test name
  elementData   expData;
  heapError     expError;
  int           mismatchCount;
  int           handshakeCount;
  int           checkedCount;
  int           assertCount;
  logic         tableReady = 1'b0;

  // --------------------------------------------------
  // Command table
  logic [191:0] names[$];
  heapAction    actions[$];
  arrayNum      arrays[$];
  elementIndex  indices[$];
  elementData   dataIns[$];
  elementData   expDatas[$];
  heapError     expErrors[$];
  int           stepCount;

  tbClock clockGen (.clock, .resetN);

  heapMemory uut (
    .clock, .resetN, .start, .action, .array, .index, .dataIn,
    .done, .dataOut, .error
  );

  heapChecker respCheck (
    .clock, .resetN, .expValid (start), .expName, .expData, .expError,
    .done, .dataOut, .error, .mismatchCount, .handshakeCount, .checkedCount
  );

  function automatic elementData pushValue(input int k);
    return elementData'(12'h100 + 12'h011 * k);
  endfunction

  task automatic addStep(input logic [191:0] name, input heapAction act, input arrayNum arr,
                         input elementIndex idx, input elementData data,
                         input elementData expValue, input heapError expectErr);
    names.push_back(name);
    actions.push_back(act);
    arrays.push_back(arr);
    indices.push_back(idx);
    dataIns.push_back(data);
    expDatas.push_back(expValue);
    expErrors.push_back(expectErr);
  endtask

  task automatic buildTable();
    addStep("reset", opReset, 2'd0, 3'd0, 12'h000, 12'h000, errNone);
    for (int a = 0; a < numArrays; a++) begin
      addStep("allocSeq", opAlloc, 2'd0, 3'd0, 12'h000, elementData'(a), errNone);
    end
    addStep("allocNone", opAlloc, 2'd0, 3'd0, 12'h000, 12'h000, errNoMemory);
    // Writes extend the size, reads stay inside it
    addStep("write0i2", opWrite, 2'd0, 3'd2, 12'h123, 12'h123, errNone);
    addStep("size0", opSize, 2'd0, 3'd0, 12'h000, 12'h003, errNone);
    addStep("read0i2", opRead, 2'd0, 3'd2, 12'h000, 12'h123, errNone);
    addStep("read0i3Oob", opRead, 2'd0, 3'd3, 12'h000, 12'h000, errOutOfBounds);
    addStep("write0i0", opWrite, 2'd0, 3'd0, 12'h0A5, 12'h0A5, errNone);
    addStep("read0i7Oob", opRead, 2'd0, 3'd7, 12'h000, 12'h000, errOutOfBounds);
    addStep("add0i2", opAdd, 2'd0, 3'd2, 12'hF00, 12'h023, errNone);  // Wraps
    addStep("read0i2Sum", opRead, 2'd0, 3'd2, 12'h000, 12'h023, errNone);
    addStep("add0i0", opAdd, 2'd0, 3'd0, 12'h001, 12'h0A6, errNone);
    addStep("add0i5Oob", opAdd, 2'd0, 3'd5, 12'h001, 12'h000, errOutOfBounds);
    addStep("read0i0Sum", opRead, 2'd0, 3'd0, 12'h000, 12'h0A6, errNone);
    // Stack use of array 1
    addStep("pop1Empty", opPop, 2'd1, 3'd0, 12'h000, 12'h000, errEmpty);
    for (int k = 0; k < arrayLength; k++) begin
      addStep("push1Fill", opPush, 2'd1, 3'd0, pushValue(k), 12'h000, errNone);
    end
    addStep("push1Full", opPush, 2'd1, 3'd0, 12'h555, 12'h000, errFull);
    addStep("size1Full", opSize, 2'd1, 3'd0, 12'h000, 12'h008, errNone);
    for (int k = arrayLength - 1; k >= 0; k--) begin
      addStep("pop1Drain", opPop, 2'd1, 3'd0, 12'h000, pushValue(k), errNone);
    end
    addStep("pop1Empty2", opPop, 2'd1, 3'd0, 12'h000, 12'h000, errEmpty);
    // Free and reuse
    addStep("write2i0", opWrite, 2'd2, 3'd0, 12'h777, 12'h777, errNone);
    addStep("free2", opFree, 2'd2, 3'd0, 12'h000, 12'h000, errNone);
    addStep("read2Freed", opRead, 2'd2, 3'd0, 12'h000, 12'h000, errFreed);
    addStep("free2Again", opFree, 2'd2, 3'd0, 12'h000, 12'h000, errFreed);
    addStep("allocReuse", opAlloc, 2'd0, 3'd0, 12'h000, 12'h002, errNone);
    addStep("size2New", opSize, 2'd2, 3'd0, 12'h000, 12'h000, errNone);
    addStep("free3", opFree, 2'd3, 3'd0, 12'h000, 12'h000, errNone);
    addStep("free1", opFree, 2'd1, 3'd0, 12'h000, 12'h000, errNone);
    addStep("allocLifoA", opAlloc, 2'd0, 3'd0, 12'h000, 12'h001, errNone);
    addStep("allocLifoB", opAlloc, 2'd0, 3'd0, 12'h000, 12'h003, errNone);
    addStep("allocNone2", opAlloc, 2'd0, 3'd0, 12'h000, 12'h000, errNoMemory);
    addStep("reset2", opReset, 2'd0, 3'd0, 12'h000, 12'h000, errNone);
    addStep("read0NotAlloc", opRead, 2'd0, 3'd0, 12'h000, 12'h000, errNotAllocated);
    addStep("alloc0Again", opAlloc, 2'd0, 3'd0, 12'h000, 12'h000, errNone);
    addStep("size1NotAlloc", opSize, 2'd1, 3'd0, 12'h000, 12'h000, errNotAllocated);
    // Unknown commands leave storage alone
    addStep("write0i1", opWrite, 2'd0, 3'd1, 12'h3C3, 12'h3C3, errNone);
    addStep("badAction9", heapAction'(8'd9), 2'd0, 3'd1, 12'hFFF, 12'h000, errBadAction);
    addStep("badActionFF", heapAction'(8'hFF), 2'd0, 3'd1, 12'hFFF, 12'h000, errBadAction);
    addStep("read0i1", opRead, 2'd0, 3'd1, 12'h000, 12'h3C3, errNone);
    addStep("size0After", opSize, 2'd0, 3'd0, 12'h000, 12'h002, errNone);
    stepCount = names.size();
  endtask

  // --------------------------------------------------
  // Stimulus
  initial begin
    start    = 1'b0;
    action   = opReset;
    array    = '0;
    index    = '0;
    dataIn   = '0;
    expName  = '0;
    expData  = '0;
    expError = errNone;
    buildTable();
    tableReady = 1'b1;
    @(posedge resetN);
    for (int i = 0; i < stepCount; i++) begin
      @(negedge clock);
      start    = 1'b1;                           // Back to back
      action   = actions[i];
      array    = arrays[i];
      index    = indices[i];
      dataIn   = dataIns[i];
      expName  = names[i];
      expData  = expDatas[i];
      expError = expErrors[i];
    end
    @(negedge clock);
    start = 1'b0;
    wait (checkedCount == stepCount);
    repeat (2) @(negedge clock);                 // Catch a stray done
    assertCount = uut.controller.assertChecks.failures;
    $display("errors: %0d mismatch, %0d handshake, %0d assertion",
             mismatchCount, handshakeCount, assertCount);
    if (mismatchCount + handshakeCount + assertCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    wait (tableReady);
    repeat (stepCount + 20) @(posedge clock);
    $display("timeout: responses not complete after %0d cycles", stepCount + 20);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- tb/heapMemory_asserts.sv
/*
  Controller assertions
  Response timing and error data rules, bound into heapController
*/
`timescale 1ns/10ps

module heapMemory_asserts import heapPkg::*, heapOpsPkg::*; (
  input logic       clock,
  input logic       resetN,
  input logic       start,
  input logic       done,
  input elementData dataOut,
  input heapError   error
);

  int failures = 0;                              // Read by the testbench top

  doneAfterStart: assert property (@(posedge clock) disable iff (!resetN) start |=> done)
    else begin
      failures++;
      $error("done did not follow start");
    end

  noDoneWithoutStart: assert property (@(posedge clock) disable iff (!resetN) !start |=> !done)
    else begin
      failures++;
      $error("done without a start one cycle earlier");
    end

  quietAfterReset: assert property (@(posedge clock) $rose(resetN) |-> !done)
    else begin
      failures++;
      $error("done high in the first cycle after reset");
    end

  zeroDataOnError: assert property (@(posedge clock) disable iff (!resetN)
                                    (error != errNone) |-> (dataOut == '0))
    else begin
      failures++;
      $error("dataOut not zero with an error code");
    end

endmodule

bind heapController heapMemory_asserts assertChecks (
  .clock, .resetN, .start, .done, .dataOut, .error
);

//--- tb/tbClock.sv
/*
  Testbench clock and reset
  8 ns clock with an active-low reset held for two cycles
*/
`timescale 1ns/10ps

module tbClock (
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;                   // 8 ns period
  end

  initial begin
    resetN = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;                               // Released away from the sampling edge
  end

endmodule
